/* mem_wb.f */
src/rv_mem_pkg.sv
src/load_store_unit.sv
src/data_ram.sv
src/mem_stage.sv
src/gpr_file.sv
src/mem_wb_top.sv
test/mem_wb_assertions.sv
test/mem_wb_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 -f mem_wb.f \
  --top-module mem_wb_tb -Mdir "$BUILD_DIR" -o mem_wb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/mem_wb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "Test passed" "$LOG"; then
  echo "simulation did not complete cleanly"
  exit 1
fi
exit 0

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
  input  logic                        clk,
  input  rv_mem_pkg::mem_bus_t        bus,
  output logic [rv_mem_pkg::XLEN-1:0] rdata
);

  import rv_mem_pkg::*;

  logic [XLEN-1:0]   mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic [2:0]        byte_sel;
  logic [7:0]        len_mask;
  logic [7:0]        byte_en;
  logic [XLEN-1:0]   lane_data;

  // 4 KiB window, higher address bits wrap.
  assign word_idx = bus.addr[RAM_AW+2:3];
  assign byte_sel = bus.addr[2:0];

  always_comb begin
    case (bus.wlen)
      4'd1: begin
        len_mask = 8'h01;
      end
      4'd2: begin
        len_mask = 8'h03;
      end
      4'd4: begin
        len_mask = 8'h0f;
      end
      4'd8: begin
        len_mask = 8'hff;
      end
      default: begin
        len_mask = 8'h00;
      end
    endcase
  end

  // aligned accesses never spill past lane 7.
  assign byte_en   = len_mask << byte_sel;
  assign lane_data = bus.wdata << {byte_sel, 3'b000};

  always_ff @(posedge clk) begin
    if (bus.wen) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) begin
          mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  // same-cycle read.
  assign rdata = bus.ren ? mem[word_idx] : '0;

endmodule

/* src/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
  input  logic                             clk,
  input  logic                             rstn,
  input  rv_mem_pkg::wb_t                  wb,
  input  logic [rv_mem_pkg::REG_IDX_W-1:0] rs1_index,
  input  logic [rv_mem_pkg::REG_IDX_W-1:0] rs2_index,
  output logic [rv_mem_pkg::XLEN-1:0]      rs1_data,
  output logic [rv_mem_pkg::XLEN-1:0]      rs2_data
);

  import rv_mem_pkg::*;

  // x0 has no storage.
  logic [XLEN-1:0] regs [1:NUM_GPRS-1];
  logic            wr_hit;

  assign wr_hit = wb.wb_en && (wb.index_rd != '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 1; i < NUM_GPRS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wb.index_rd] <= wb.wb_data;
    end
  end

  always_comb begin
    if (rs1_index == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_index];
    end
  end

  always_comb begin
    if (rs2_index == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_index];
    end
  end

endmodule

/* src/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
  input  logic                            load_en,
  input  logic                            store_en,
  input  logic [rv_mem_pkg::LEN_W-1:0]    store_len,
  input  logic [rv_mem_pkg::LD_OP_W-1:0]  load_opcode,
  input  logic [rv_mem_pkg::XLEN-1:0]     store_data,
  input  logic [rv_mem_pkg::XLEN-1:0]     address,
  input  logic [rv_mem_pkg::XLEN-1:0]     rdata,
  output rv_mem_pkg::mem_bus_t            bus,
  output logic [rv_mem_pkg::XLEN-1:0]     load_data
);

  import rv_mem_pkg::*;

  logic [2:0]      byte_off;
  logic [XLEN-1:0] shifted;

  assign byte_off = address[2:0];

  // store side.
  always_comb begin
    bus.addr  = address;
    bus.wdata = store_data;
    bus.wlen  = store_len;
    bus.wen   = store_en;
    // a store wins if both are ever raised.
    bus.ren   = load_en & ~store_en;
  end

  // bring the addressed byte down to lane 0.
  assign shifted = rdata >> {byte_off, 3'b000};

  always_comb begin
    case (load_opcode)
      LD_B: begin
        load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      LD_H: begin
        load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      LD_W: begin
        load_data = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      LD_D: begin
        load_data = shifted;
      end
      LD_BU: begin
        load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
      end
      LD_HU: begin
        load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
      end
      LD_WU: begin
        load_data = {{(XLEN-32){1'b0}}, shifted[31:0]};
      end
      default: begin
        load_data = '0;
      end
    endcase
  end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
  input  logic                            clk,
  input  logic                            rstn,
  input  rv_mem_pkg::exu_to_mem_t         exu,
  input  logic [rv_mem_pkg::XLEN-1:0]     load_data,
  output logic                            load_en,
  output logic                            store_en,
  output logic [rv_mem_pkg::LEN_W-1:0]    store_len,
  output logic [rv_mem_pkg::LD_OP_W-1:0]  load_opcode,
  output logic [rv_mem_pkg::XLEN-1:0]     store_data,
  output logic [rv_mem_pkg::XLEN-1:0]     address,
  output rv_mem_pkg::redirect_t           redirect,
  output rv_mem_pkg::wb_t                 wb,
  output logic                            ebreak
);

  import rv_mem_pkg::*;

  logic                 branch_taken;
  logic [REG_IDX_W-1:0] rd_q;
  logic                 wb_en_q;
  logic [WB_SEL_W-1:0]  wb_sel_q;
  logic [XLEN-1:0]      alu_q;
  logic [XLEN-1:0]      load_q;
  logic [XLEN-1:0]      imm_q;
  logic [XLEN-1:0]      wb_data;

  // next pc in the same cycle.
  assign branch_taken = exu.branch_en & exu.branch_result;

  always_comb begin
    redirect.jump_en   = exu.jump_en;
    redirect.branch_en = branch_taken;
    if (exu.jump_en) begin
      redirect.dnpc = exu.alu_result;
    end else if (branch_taken) begin
      redirect.dnpc = exu.branch_pc;
    end else begin
      redirect.dnpc = '0;
    end
  end

  // alu result doubles as the data address.
  assign load_en     = exu.load_en;
  assign store_en    = exu.store_en;
  assign store_len   = exu.store_len;
  assign load_opcode = exu.load_opcode;
  assign store_data  = exu.gpr_data2;
  assign address     = exu.alu_result;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_q     <= '0;
      wb_en_q  <= 1'b0;
      wb_sel_q <= '0;
      ebreak   <= 1'b0;
    end else begin
      rd_q     <= exu.index_rd;
      wb_en_q  <= exu.wb_en;
      wb_sel_q <= exu.wb_choose;
      ebreak   <= exu.ebreak;
    end
  end

  always_ff @(posedge clk) begin
    alu_q  <= exu.alu_result;
    load_q <= load_data;
    imm_q  <= exu.imm;
  end

  // bad select codes give zero.
  always_comb begin
    case (wb_sel_q)
      WB_ALU: begin
        wb_data = alu_q;
      end
      WB_LOAD: begin
        wb_data = load_q;
      end
      WB_IMM: begin
        wb_data = imm_q;
      end
      default: begin
        wb_data = '0;
      end
    endcase
  end

  always_comb begin
    wb.index_rd = rd_q;
    wb.wb_en    = wb_en_q;
    wb.wb_data  = wb_data;
  end

endmodule

/* src/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
  input  logic                             clk,
  input  logic                             rstn,
  input  rv_mem_pkg::exu_to_mem_t          exu,
  input  logic [rv_mem_pkg::REG_IDX_W-1:0] rs1_index,
  input  logic [rv_mem_pkg::REG_IDX_W-1:0] rs2_index,
  output rv_mem_pkg::redirect_t            redirect,
  output rv_mem_pkg::wb_t                  wb,
  output logic                             ebreak,
  output logic [rv_mem_pkg::XLEN-1:0]      rs1_data,
  output logic [rv_mem_pkg::XLEN-1:0]      rs2_data
);

  import rv_mem_pkg::*;

  logic               load_en;
  logic               store_en;
  logic [LEN_W-1:0]   store_len;
  logic [LD_OP_W-1:0] load_opcode;
  logic [XLEN-1:0]    store_data;
  logic [XLEN-1:0]    address;
  logic [XLEN-1:0]    load_data;
  logic [XLEN-1:0]    rdata;
  mem_bus_t           bus;

  mem_stage u_mem_stage (
    .clk         (clk),
    .rstn        (rstn),
    .exu         (exu),
    .load_data   (load_data),
    .load_en     (load_en),
    .store_en    (store_en),
    .store_len   (store_len),
    .load_opcode (load_opcode),
    .store_data  (store_data),
    .address     (address),
    .redirect    (redirect),
    .wb          (wb),
    .ebreak      (ebreak)
  );

  load_store_unit u_lsu (
    .load_en     (load_en),
    .store_en    (store_en),
    .store_len   (store_len),
    .load_opcode (load_opcode),
    .store_data  (store_data),
    .address     (address),
    .rdata       (rdata),
    .bus         (bus),
    .load_data   (load_data)
  );

  data_ram u_data_ram (
    .clk   (clk),
    .bus   (bus),
    .rdata (rdata)
  );

  gpr_file u_gpr_file (
    .clk       (clk),
    .rstn      (rstn),
    .wb        (wb),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

endmodule

/* src/rv_mem_pkg.sv */
package rv_mem_pkg;

  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;
  localparam int NUM_GPRS  = 32;
  localparam int RAM_WORDS = 512;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int LEN_W     = 4;
  localparam int LD_OP_W   = 3;
  localparam int WB_SEL_W  = 3;

  // load opcodes, low two bits give the size.
  localparam logic [LD_OP_W-1:0] LD_B  = 3'd0;
  localparam logic [LD_OP_W-1:0] LD_H  = 3'd1;
  localparam logic [LD_OP_W-1:0] LD_W  = 3'd2;
  localparam logic [LD_OP_W-1:0] LD_D  = 3'd3;
  localparam logic [LD_OP_W-1:0] LD_BU = 3'd4;
  localparam logic [LD_OP_W-1:0] LD_HU = 3'd5;
  localparam logic [LD_OP_W-1:0] LD_WU = 3'd6;

  // writeback source, one-hot.
  localparam logic [WB_SEL_W-1:0] WB_ALU  = 3'b001;
  localparam logic [WB_SEL_W-1:0] WB_LOAD = 3'b010;
  localparam logic [WB_SEL_W-1:0] WB_IMM  = 3'b100;

  typedef struct packed {
    logic [REG_IDX_W-1:0] index_rd;
    logic                 jump_en;
    logic                 branch_en;
    logic                 branch_result;
    logic [XLEN-1:0]      branch_pc;
    logic [XLEN-1:0]      alu_result;
    logic                 load_en;
    logic                 store_en;
    logic [LEN_W-1:0]     store_len;
    logic [XLEN-1:0]      gpr_data2;
    logic [XLEN-1:0]      imm;
    logic [LD_OP_W-1:0]   load_opcode;
    logic                 wb_en;
    logic [WB_SEL_W-1:0]  wb_choose;
    logic                 ebreak;
  } exu_to_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  wdata;
    logic [LEN_W-1:0] wlen;
    logic             wen;
    logic             ren;
  } mem_bus_t;

  typedef struct packed {
    logic [XLEN-1:0] dnpc;
    logic            jump_en;
    logic            branch_en;
  } redirect_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] index_rd;
    logic                 wb_en;
    logic [XLEN-1:0]      wb_data;
  } wb_t;

endpackage

/* test/mem_wb_assertions.sv */
`timescale 1ns/1ps

module mem_wb_assertions (
  input logic                          clk,
  input logic                          rstn,
  input logic                          load_en,
  input logic                          store_en,
  input logic [rv_mem_pkg::LEN_W-1:0]  store_len,
  input rv_mem_pkg::redirect_t         redirect,
  input rv_mem_pkg::wb_t               wb,
  input logic                          ebreak
);

  // wen follows store_en and ren follows load_en.
  bus_enables_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    !(store_en && load_en))
    else $error("load and store presented to the bus in the same cycle");

  store_len_legal: assert property (@(posedge clk) disable iff (!rstn)
    store_en |-> (store_len inside {4'd1, 4'd2, 4'd4, 4'd8}))
    else $error("store length %0d is not 1, 2, 4 or 8", store_len);

  dnpc_idle_zero: assert property (@(posedge clk) disable iff (!rstn)
    !(redirect.jump_en || redirect.branch_en) |-> (redirect.dnpc == '0))
    else $error("dnpc is nonzero without a jump or taken branch");

  // values seen at the first edge after release are still the reset values.
  reset_release_quiet: assert property (@(posedge clk)
    $rose(rstn) |-> (!wb.wb_en && !ebreak))
    else $error("wb_en or ebreak high right after reset release");

endmodule

bind mem_stage mem_wb_assertions u_mem_wb_assertions (
  .clk       (clk),
  .rstn      (rstn),
  .load_en   (load_en),
  .store_en  (store_en),
  .store_len (store_len),
  .redirect  (redirect),
  .wb        (wb),
  .ebreak    (ebreak)
);

/* test/mem_wb_tb.sv */
`timescale 1ns/1ps

module mem_wb_tb;

  import rv_mem_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ROWS     = 40;
  localparam int MEM_BYTES    = 4096;
  localparam int WATCHDOG_NS  = (NUM_ROWS + 20) * CLK_PERIOD;

  // operation kinds.
  localparam logic [2:0] K_STORE  = 3'd0;
  localparam logic [2:0] K_LOAD   = 3'd1;
  localparam logic [2:0] K_ALU    = 3'd2;
  localparam logic [2:0] K_IMM    = 3'd3;
  localparam logic [2:0] K_JUMP   = 3'd4;
  localparam logic [2:0] K_BRANCH = 3'd5;
  localparam logic [2:0] K_EBREAK = 3'd6;
  localparam logic [2:0] K_NOP    = 3'd7;

  // sub is the store length or the load opcode, flag is wb_en or branch_result.
  typedef struct packed {
    logic [2:0]           kind;
    logic [XLEN-1:0]      addr;
    logic [3:0]           sub;
    logic [REG_IDX_W-1:0] rd;
    logic [WB_SEL_W-1:0]  sel;
    logic                 flag;
    logic [XLEN-1:0]      exp_dnpc;
  } row_t;

  logic                 clk;
  logic                 rstn;
  exu_to_mem_t          exu;
  logic [REG_IDX_W-1:0] rs1_index;
  logic [REG_IDX_W-1:0] rs2_index;
  redirect_t            redirect;
  wb_t                  wb;
  logic                 ebreak;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;

  row_t            table_rows [NUM_ROWS];
  int              row_count;
  integer          seed;
  logic [7:0]      mem_model [MEM_BYTES];
  logic [XLEN-1:0] reg_model [NUM_GPRS];
  wb_t             exp_wb;
  wb_t             pend_wb;
  logic            exp_ebreak;

  mem_wb_top uut (
    .clk       (clk),
    .rstn      (rstn),
    .exu       (exu),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .redirect  (redirect),
    .wb        (wb),
    .ebreak    (ebreak),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "check on %s", name);
    end
  endtask

  task automatic add_row(input logic [2:0] kind, input logic [XLEN-1:0] addr,
                         input logic [3:0] sub, input logic [REG_IDX_W-1:0] rd,
                         input logic [WB_SEL_W-1:0] sel, input logic flag,
                         input logic [XLEN-1:0] exp_dnpc);
    table_rows[row_count] = '{kind, addr, sub, rd, sel, flag, exp_dnpc};
    row_count++;
  endtask

  task automatic fill_table();
    row_count = 0;
    add_row(K_STORE,  64'h100,       4'd8,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_STORE,  64'h108,       4'd8,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_STORE,  64'h110,       4'd8,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_STORE,  64'h103,       4'd1,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_STORE,  64'h10a,       4'd2,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_STORE,  64'h114,       4'd4,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_LOAD,   64'h100,       4'(LD_D),   5'd5,  WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h103,       4'(LD_B),   5'd6,  WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h103,       4'(LD_BU),  5'd7,  WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h10a,       4'(LD_H),   5'd8,  WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h10a,       4'(LD_HU),  5'd9,  WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h114,       4'(LD_W),   5'd10, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h114,       4'(LD_WU),  5'd11, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h108,       4'(LD_D),   5'd12, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h110,       4'(LD_D),   5'd13, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h116,       4'(LD_H),   5'd14, WB_LOAD, 1'b1, 64'h0);
    add_row(K_STORE,  64'hff8,       4'd8,       5'd0,  3'b000,  1'b0, 64'h0);
    // upper address bits wrap onto the 4 KiB window.
    add_row(K_STORE,  64'h1ffe,      4'd2,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_LOAD,   64'hffe,       4'(LD_HU),  5'd15, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'hff8,       4'(LD_D),   5'd16, WB_LOAD, 1'b1, 64'h0);
    add_row(K_ALU,    64'hdead_beef_0123_4567, 4'd0, 5'd1, WB_ALU, 1'b1, 64'h0);
    add_row(K_IMM,    64'h55,        4'd0,       5'd2,  WB_IMM,  1'b1, 64'h0);
    add_row(K_ALU,    64'h1234,      4'd0,       5'd3,  3'b011,  1'b1, 64'h0);
    add_row(K_ALU,    64'h5678,      4'd0,       5'd4,  3'b000,  1'b1, 64'h0);
    add_row(K_ALU,    64'hffff_0000, 4'd0,       5'd0,  WB_ALU,  1'b1, 64'h0);
    add_row(K_IMM,    64'h0,         4'd0,       5'd1,  WB_IMM,  1'b0, 64'h0);
    add_row(K_ALU,    64'h7777_8888, 4'd0,       5'd17, WB_ALU,  1'b1, 64'h0);
    add_row(K_JUMP,   64'h8000_1000, 4'd0,       5'd0,  3'b000,  1'b0, 64'h8000_1000);
    add_row(K_BRANCH, 64'h8000_2000, 4'd0,       5'd0,  3'b000,  1'b1, 64'h8000_2000);
    add_row(K_BRANCH, 64'h8000_3000, 4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_EBREAK, 64'h0,         4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_NOP,    64'h0,         4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_EBREAK, 64'h0,         4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_ALU,    64'h0bad_cafe, 4'd0,       5'd31, WB_ALU,  1'b1, 64'h0);
    add_row(K_IMM,    64'h0,         4'd0,       5'd30, WB_IMM,  1'b1, 64'h0);
    add_row(K_LOAD,   64'h100,       4'(LD_B),   5'd29, WB_LOAD, 1'b1, 64'h0);
    add_row(K_LOAD,   64'h107,       4'(LD_BU),  5'd28, WB_LOAD, 1'b1, 64'h0);
    add_row(K_JUMP,   64'h4,         4'd0,       5'd0,  3'b000,  1'b0, 64'h4);
    add_row(K_NOP,    64'h0,         4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
    add_row(K_NOP,    64'h0,         4'd0,       5'd0,  3'b000,  1'b0, 64'h0);
  endtask

  task automatic store_model(input logic [XLEN-1:0] addr, input logic [3:0] len,
                             input logic [XLEN-1:0] data);
    logic [11:0] byte_addr;
    for (int i = 0; i < int'(len); i++) begin
      byte_addr = addr[11:0] + i[11:0];
      mem_model[byte_addr] = data[8*i +: 8];
    end
  endtask

  function automatic logic [XLEN-1:0] load_model(input logic [XLEN-1:0] addr,
                                                 input logic [2:0] op);
    logic [XLEN-1:0] val;
    logic [11:0]     byte_addr;
    int              size;
    val  = '0;
    size = 1 << op[1:0];
    for (int i = 0; i < size; i++) begin
      byte_addr = addr[11:0] + i[11:0];
      val[8*i +: 8] = mem_model[byte_addr];
    end
    // signed opcodes copy the top loaded bit upward.
    if (!op[2] && size < 8 && val[8*size-1]) begin
      val = val | ~((64'd1 << (8 * size)) - 64'd1);
    end
    return val;
  endfunction

  task automatic drive_row(input row_t r, input int k);
    logic [XLEN-1:0] rnd_data;
    logic [XLEN-1:0] load_val;
    rnd_data = {$random(seed), $random(seed)};
    load_val = '0;
    exu = '0;
    exu.alu_result = r.addr;
    exu.gpr_data2  = rnd_data;
    exu.branch_pc  = rnd_data;
    exu.imm        = {$random(seed), $random(seed)};
    case (r.kind)
      K_STORE: begin
        exu.store_en  = 1'b1;
        exu.store_len = r.sub;
        store_model(r.addr, r.sub, rnd_data);
      end
      K_LOAD: begin
        exu.load_en     = 1'b1;
        exu.load_opcode = r.sub[2:0];
        load_val        = load_model(r.addr, r.sub[2:0]);
      end
      K_JUMP: exu.jump_en = 1'b1;
      K_BRANCH: begin
        exu.branch_en     = 1'b1;
        exu.branch_result = r.flag;
        exu.branch_pc     = r.addr;
        exu.alu_result    = rnd_data;
      end
      K_EBREAK: exu.ebreak = 1'b1;
      default: ;
    endcase
    if (r.kind == K_LOAD || r.kind == K_ALU || r.kind == K_IMM) begin
      exu.index_rd  = r.rd;
      exu.wb_en     = r.flag;
      exu.wb_choose = r.sel;
    end
    exp_wb.index_rd = exu.index_rd;
    exp_wb.wb_en    = exu.wb_en;
    case (exu.wb_choose)
      WB_ALU:  exp_wb.wb_data = exu.alu_result;
      WB_LOAD: exp_wb.wb_data = load_val;
      WB_IMM:  exp_wb.wb_data = exu.imm;
      default: exp_wb.wb_data = '0;
    endcase
    exp_ebreak = exu.ebreak;
    // rs1 trails by two rows, rs2 by one.
    rs1_index = '0;
    rs2_index = 5'(k);
    if (k >= 2) begin
      rs1_index = table_rows[k-2].rd;
    end
    if (k >= 1 && table_rows[k-1].rd != '0) begin
      rs2_index = table_rows[k-1].rd;
    end
  endtask

  task automatic check_reads();
    check_value("rs1_data", rs1_data, reg_model[rs1_index]);
    check_value("rs2_data", rs2_data, reg_model[rs2_index]);
  endtask

  task automatic check_redirect(input row_t r);
    check_value("redirect.jump_en", 64'(redirect.jump_en), 64'(r.kind == K_JUMP));
    check_value("redirect.branch_en", 64'(redirect.branch_en),
                64'(r.kind == K_BRANCH && r.flag));
    check_value("redirect.dnpc", redirect.dnpc, r.exp_dnpc);
  endtask

  // the write seen one cycle ago landed at the edge just passed.
  task automatic retire_previous();
    if (pend_wb.wb_en && pend_wb.index_rd != '0) begin
      reg_model[pend_wb.index_rd] = pend_wb.wb_data;
    end
    check_reads();
    check_value("wb.index_rd", 64'(wb.index_rd), 64'(exp_wb.index_rd));
    check_value("wb.wb_en", 64'(wb.wb_en), 64'(exp_wb.wb_en));
    check_value("wb.wb_data", wb.wb_data, exp_wb.wb_data);
    check_value("ebreak", 64'(ebreak), 64'(exp_ebreak));
    pend_wb = exp_wb;
  endtask

  task automatic check_after_reset();
    check_value("wb.wb_en", 64'(wb.wb_en), 64'd0);
    check_value("ebreak", 64'(ebreak), 64'd0);
    check_value("redirect.jump_en", 64'(redirect.jump_en), 64'd0);
    check_value("redirect.branch_en", 64'(redirect.branch_en), 64'd0);
    for (int i = 0; i < NUM_GPRS; i++) begin
      rs1_index = 5'(i);
      rs2_index = 5'(NUM_GPRS - 1 - i);
      #1;
      check_value("rs1_data", rs1_data, 64'd0);
      check_value("rs2_data", rs2_data, 64'd0);
    end
  endtask

  initial begin
    seed       = 32'hea3f336d;
    rstn       = 1'b0;
    exu        = '0;
    rs1_index  = '0;
    rs2_index  = '0;
    exp_wb     = '0;
    pend_wb    = '0;
    exp_ebreak = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_model[a] = 8'h00;
    end
    for (int r = 0; r < NUM_GPRS; r++) begin
      reg_model[r] = '0;
    end
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rstn = 1'b1;
    check_after_reset();
    @(posedge clk);
    #(DRIVE_DELAY);
    for (int k = 0; k < row_count; k++) begin
      retire_previous();
      drive_row(table_rows[k], k);
      @(negedge clk);
      check_redirect(table_rows[k]);
      check_reads();
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    retire_previous();
    $display("Test passed");
    $finish;
  end

endmodule
